//--- Makefile
# Verilator build and run for the shift-group CPU core

.PHONY: run clean

obj_dir/Vcpu_core_tb: list.f $(wildcard logic/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --top-module cpu_core_tb -f list.f

# The test data is read from test/ at run time, so run from the project root
run: obj_dir/Vcpu_core_tb
	obj_dir/Vcpu_core_tb | tee /dev/stderr | grep -q "^All tests passed$$"

clean:
	rm -rf obj_dir

//--- list.f
logic/cpu_pkg.sv
logic/shift_alu.sv
logic/instruction_decode.sv
logic/datapath.sv
logic/cpu_core.sv
test/clock_gen.sv
test/cpu_core_tb.sv

//--- logic/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        rdy,
    input  logic [7:0]  data_in,
    output logic [15:0] address,
    output logic [7:0]  data_out,
    output logic        rw
);

    alu_op_t     alu_op;
    logic [6:0]  flag_write_mask;
    logic        status_write;
    addr_sel_t   addr_sel;
    buf2_t       latch_ctl;
    buf2_t       dbuf_ctl;
    logic        pc_inc;
    reg_ctl_t    acc_ctl;
    reg_ctl_t    x_ctl;
    reg_ctl_t    sp_ctl;
    logic [15:0] operand_address;
    logic [7:0]  alu_a;
    logic [7:0]  alu_b;
    logic [7:0]  alu_result;
    logic        carry_out;
    logic        zero_out;
    logic        negative_out;

    instruction_decode decode (
        .clk, .reset, .rdy, .instruction(data_in), .alu_op, .flag_write_mask,
        .status_write, .addr_sel, .rw, .latch_ctl, .dbuf_ctl, .pc_inc,
        .acc_ctl, .x_ctl, .sp_ctl, .operand_address
    );

    datapath path (
        .clk, .reset, .rdy, .alu_op, .flag_write_mask, .status_write, .addr_sel,
        .rw, .latch_ctl, .dbuf_ctl, .pc_inc, .acc_ctl, .x_ctl, .sp_ctl,
        .operand_address, .data_in, .alu_result, .carry_out, .zero_out,
        .negative_out, .address, .data_out, .alu_a, .alu_b
    );

    shift_alu alu (
        .op(alu_op), .a(alu_a), .b(alu_b), .carry_in(1'b0), .result(alu_result),
        .carry_out, .zero_out, .negative_out
    );

endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam logic [7:0] op_asl_a     = 8'h0A;
    localparam logic [7:0] op_asl_zpg   = 8'h06;
    localparam logic [7:0] op_asl_zpg_x = 8'h16;
    localparam logic [7:0] op_asl_abs   = 8'h0E;
    localparam logic [7:0] op_lsr_a     = 8'h4A;
    localparam logic [7:0] op_lsr_zpg   = 8'h46;
    localparam logic [7:0] op_lsr_zpg_x = 8'h56;
    localparam logic [7:0] op_lsr_abs   = 8'h4E;
    localparam logic [7:0] op_lda_imm   = 8'hA9;
    localparam logic [7:0] op_ldx_imm   = 8'hA2;
    localparam logic [7:0] op_sta_zpg   = 8'h85;
    localparam logic [7:0] op_php       = 8'h08;
    localparam logic [7:0] op_nop       = 8'hEA;

    // Shift group modes match opcode bits 4 to 2
    typedef enum logic [2:0] {
        adr_imm   = 3'b000,
        adr_zpg   = 3'b001,
        adr_a     = 3'b010,
        adr_abs   = 3'b011,
        adr_zpg_x = 3'b101
    } addr_mode_t;

    typedef enum logic [2:0] {alu_nop, alu_asl, alu_lsr, alu_add, alu_tmx} alu_op_t;

    typedef enum logic [1:0] {buf_idle = 2'b00, buf_load = 2'b01, buf_store = 2'b10} buf2_t;

    // Bit 2 is enable, bit 1 is load (1) or drive (0), bit 0 is the bus select
    typedef logic [2:0] reg_ctl_t;
    localparam reg_ctl_t reg_idle      = 3'b000;
    localparam reg_ctl_t reg_load_alu  = 3'b110;
    localparam reg_ctl_t reg_drive_alu = 3'b100;

    localparam int carry_bit    = 0;
    localparam int zero_bit     = 1;
    localparam int negative_bit = 6;

    typedef enum logic [1:0] {sel_pc, sel_operand, sel_alu} addr_sel_t;

    typedef enum logic [3:0] {
        st_idle, st_opcode_read, st_adr_read, st_abs_lb, st_abs_hb, st_abs_adr,
        st_adr_calc_1, st_adr_calc_2, st_data_read, st_acc_copy, st_alu_final,
        st_alu_tmx, st_dbuf_output, st_imm_read, st_push_load, st_push_write
    } state_t;

endpackage

`default_nettype wire

//--- logic/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        rdy,
    input  alu_op_t     alu_op,
    input  logic [6:0]  flag_write_mask,
    input  logic        status_write,
    input  addr_sel_t   addr_sel,
    input  logic        rw,
    input  buf2_t       latch_ctl,
    input  buf2_t       dbuf_ctl,
    input  logic        pc_inc,
    input  reg_ctl_t    acc_ctl,
    input  reg_ctl_t    x_ctl,
    input  reg_ctl_t    sp_ctl,
    input  logic [15:0] operand_address,
    input  logic [7:0]  data_in,
    input  logic [7:0]  alu_result,
    input  logic        carry_out,
    input  logic        zero_out,
    input  logic        negative_out,
    output logic [15:0] address,
    output logic [7:0]  data_out,
    output logic [7:0]  alu_a,
    output logic [7:0]  alu_b
);

    logic [15:0] pc;
    logic [7:0]  acc;
    logic [7:0]  x_reg;
    logic [7:0]  sp;
    logic [7:0]  idl;
    logic [7:0]  dbuf;
    logic [6:0]  status;
    logic [6:0]  flags;
    logic [7:0]  status_byte;

    assign flags = (7'b1 << carry_bit) & {7{carry_out}} |
                   (7'b1 << zero_bit) & {7{zero_out}} |
                   (7'b1 << negative_bit) & {7{negative_out}};

    // Pushed in the usual N V 1 B D I Z C order
    assign status_byte = {status[6], status[5], 1'b1, status[4:0]};

    always_comb begin
        if (acc_ctl == reg_drive_alu)
            alu_a = acc;
        else if (x_ctl == reg_drive_alu)
            alu_a = operand_address[7:0]; // Zero page base for the X add
        else if (latch_ctl != buf_idle)
            alu_a = idl;
        else if (dbuf_ctl == buf_load)
            alu_a = status_byte;
        else
            alu_a = data_in;
    end

    assign alu_b = (x_ctl == reg_drive_alu) ? x_reg : 8'h00;

    always_comb begin
        case (addr_sel)
            sel_operand: address = operand_address;
            sel_alu:     address = (sp_ctl == reg_drive_alu) ? {8'h01, sp} : {8'h00, alu_result};
            default:     address = pc;
        endcase
    end

    // Output buffer reaches the pins only on a write cycle
    assign data_out = (dbuf_ctl == buf_store && !rw) ? dbuf : 8'h00;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= 16'h0000;
            acc    <= 8'h00;
            x_reg  <= 8'h00;
            sp     <= 8'hFF;
            status <= 7'b0;
        end else if (rdy) begin
            if (pc_inc)
                pc <= pc + 16'd1;
            if (acc_ctl == reg_load_alu)
                acc <= alu_result;
            if (x_ctl == reg_load_alu)
                x_reg <= alu_result;
            if (sp_ctl == reg_drive_alu)
                sp <= sp - 8'd1; // Post-decrement after a push
            if (status_write)
                status <= (status & ~flag_write_mask) | (flags & flag_write_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (latch_ctl == buf_load)
                idl <= data_in;
            else if (latch_ctl == buf_store)
                idl <= alu_result; // Read-modify-write through the ALU
            if (dbuf_ctl == buf_load)
                dbuf <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- logic/instruction_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_decode import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        rdy,
    input  logic [7:0]  instruction,
    output alu_op_t     alu_op,
    output logic [6:0]  flag_write_mask,
    output logic        status_write,
    output addr_sel_t   addr_sel,
    output logic        rw,
    output buf2_t       latch_ctl,
    output buf2_t       dbuf_ctl,
    output logic        pc_inc,
    output reg_ctl_t    acc_ctl,
    output reg_ctl_t    x_ctl,
    output reg_ctl_t    sp_ctl,
    output logic [15:0] operand_address
);

    state_t     state;
    state_t     next_state;
    logic [7:0] opcode;
    addr_mode_t mode;

    function automatic logic is_shift(input logic [7:0] op);
        return (op[1:0] == 2'b10) && (op[7:5] == 3'b000 || op[7:5] == 3'b010) &&
               (op[4:2] == adr_zpg || op[4:2] == adr_a || op[4:2] == adr_abs ||
                op[4:2] == adr_zpg_x);
    endfunction

    function automatic addr_mode_t decode_mode(input logic [7:0] op);
        if (is_shift(op))
            return addr_mode_t'(op[4:2]);
        else if (op == op_lda_imm || op == op_ldx_imm)
            return adr_imm;
        else if (op == op_sta_zpg)
            return adr_zpg;
        return adr_a; // Implied helpers carry no operand
    endfunction

    always_comb begin
        next_state      = state;
        alu_op          = alu_nop;
        flag_write_mask = 7'b0;
        status_write    = 1'b0;
        addr_sel        = sel_pc;
        rw              = 1'b1;
        latch_ctl       = buf_idle;
        dbuf_ctl        = buf_idle;
        pc_inc          = 1'b0;
        acc_ctl         = reg_idle;
        x_ctl           = reg_idle;
        sp_ctl          = reg_idle;
        case (state)
            st_idle: begin
                next_state = st_opcode_read;
            end
            st_opcode_read: begin
                pc_inc = 1'b1;
                if (is_shift(instruction)) begin
                    case (decode_mode(instruction))
                        adr_abs: next_state = st_abs_lb;
                        adr_a:   next_state = st_acc_copy;
                        default: next_state = st_adr_read; // Zero page with or without X
                    endcase
                end else if (instruction == op_lda_imm || instruction == op_ldx_imm) begin
                    next_state = st_imm_read;
                end else if (instruction == op_sta_zpg) begin
                    next_state = st_adr_read;
                end else if (instruction == op_php) begin
                    next_state = st_push_load;
                end else begin
                    next_state = st_opcode_read; // NOP and unknown opcodes
                end
            end
            st_adr_read: begin
                pc_inc = 1'b1;
                if (opcode == op_sta_zpg) begin
                    acc_ctl    = reg_drive_alu; // Accumulator goes to the output buffer
                    alu_op     = alu_tmx;
                    dbuf_ctl   = buf_load;
                    next_state = st_dbuf_output;
                end else if (mode == adr_zpg_x) begin
                    next_state = st_adr_calc_1;
                end else begin
                    next_state = st_data_read;
                end
            end
            st_abs_lb: begin
                pc_inc     = 1'b1;
                next_state = st_abs_hb;
            end
            st_abs_hb: begin
                pc_inc     = 1'b1;
                next_state = st_abs_adr;
            end
            st_abs_adr: begin
                addr_sel   = sel_operand; // Dummy read while the address settles
                next_state = st_data_read;
            end
            st_adr_calc_1: begin
                x_ctl      = reg_drive_alu;
                alu_op     = alu_add;
                next_state = st_adr_calc_2;
            end
            st_adr_calc_2: begin
                x_ctl      = reg_drive_alu;
                alu_op     = alu_add;
                addr_sel   = sel_alu;
                next_state = st_data_read;
            end
            st_data_read: begin
                latch_ctl = buf_load;
                if (mode == adr_zpg_x) begin
                    x_ctl    = reg_drive_alu;
                    alu_op   = alu_add;
                    addr_sel = sel_alu;
                end else begin
                    addr_sel = sel_operand;
                end
                next_state = st_alu_final;
            end
            st_acc_copy: begin
                acc_ctl    = reg_drive_alu;
                latch_ctl  = buf_store;
                alu_op     = alu_tmx;
                next_state = st_alu_final;
            end
            st_alu_final: begin
                latch_ctl       = buf_store;
                alu_op          = (opcode[7:5] == 3'b010) ? alu_lsr : alu_asl;
                status_write    = 1'b1;
                flag_write_mask = 7'b0;
                flag_write_mask[carry_bit]    = 1'b1;
                flag_write_mask[zero_bit]     = 1'b1;
                flag_write_mask[negative_bit] = 1'b1;
                next_state      = st_alu_tmx;
            end
            st_alu_tmx: begin
                latch_ctl = buf_store;
                alu_op    = alu_tmx;
                if (mode == adr_a) begin
                    acc_ctl    = reg_load_alu;
                    next_state = st_opcode_read;
                end else begin
                    dbuf_ctl   = buf_load;
                    next_state = st_dbuf_output;
                end
            end
            st_dbuf_output: begin
                dbuf_ctl = buf_store;
                rw       = 1'b0;
                if (mode == adr_zpg_x) begin
                    x_ctl    = reg_drive_alu; // Indexed address is formed again here
                    alu_op   = alu_add;
                    addr_sel = sel_alu;
                end else begin
                    addr_sel = sel_operand;
                end
                next_state = st_opcode_read;
            end
            st_imm_read: begin
                pc_inc       = 1'b1;
                alu_op       = alu_tmx;
                status_write = 1'b1;
                flag_write_mask[zero_bit]     = 1'b1;
                flag_write_mask[negative_bit] = 1'b1;
                if (opcode == op_ldx_imm)
                    x_ctl = reg_load_alu;
                else
                    acc_ctl = reg_load_alu;
                next_state = st_opcode_read;
            end
            st_push_load: begin
                alu_op     = alu_tmx;
                dbuf_ctl   = buf_load; // Status byte is the default source here
                next_state = st_push_write;
            end
            st_push_write: begin
                sp_ctl     = reg_drive_alu;
                addr_sel   = sel_alu;
                dbuf_ctl   = buf_store;
                rw         = 1'b0;
                next_state = st_opcode_read;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= st_idle;
            opcode          <= op_nop;
            mode            <= adr_a;
            operand_address <= 16'h0000;
        end else if (rdy) begin
            state <= next_state;
            case (state)
                st_opcode_read: begin
                    opcode <= instruction;
                    mode   <= decode_mode(instruction);
                end
                st_adr_read, st_abs_lb: operand_address <= {8'h00, instruction}; // Low byte first
                st_abs_hb:              operand_address[15:8] <= instruction;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/shift_alu.sv
`timescale 1ns/1ns
`default_nettype none

module shift_alu import cpu_pkg::*; (
    input  alu_op_t    op,
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic       carry_in,
    output logic [7:0] result,
    output logic       carry_out,
    output logic       zero_out,
    output logic       negative_out
);

    always_comb begin
        result    = 8'h00;
        carry_out = carry_in;
        case (op)
            alu_asl: begin
                {carry_out, result} = {a, 1'b0}; // Bit 7 falls into the carry
            end
            alu_lsr: begin
                result    = {1'b0, a[7:1]};
                carry_out = a[0];
            end
            alu_add: begin
                {carry_out, result} = {1'b0, a} + {1'b0, b} + {8'h00, carry_in}; // Page zero wraps
            end
            alu_tmx: begin
                result = a;
            end
            default: begin
                result = 8'h00;
            end
        endcase
    end

    assign zero_out     = (result == 8'h00);
    assign negative_out = result[7];

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0; // Released just after the edge like the other inputs
    end

endmodule

`default_nettype wire

//--- test/cpu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;

    logic        clk;
    logic        por_reset;
    logic        test_reset;
    logic        hold_reset;
    logic        rdy;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        rw;

    logic [7:0]  mem [0:65535];
    logic [7:0]  lfsr;
    logic        write_pending;
    logic [15:0] pending_address;
    logic [7:0]  pending_data;
    logic [23:0] seen_writes [$];
    logic        timed_out;
    int          check_count;
    int          mismatch_count;
    int          failure_count;

    clock_gen clock (.clk, .reset(por_reset));

    cpu_core UUT (
        .clk, .reset(por_reset | test_reset), .rdy, .data_in, .address, .data_out, .rw
    );

    assign data_in = mem[address]; // Reads answer in the same cycle

    // Taps 8, 6, 5 and 4 give a maximal length sequence
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic choose_rdy();
        logic [1:0] bits;
        lfsr = lfsr_next(lfsr);
        bits[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        bits[1] = lfsr[0];
        rdy = ~&bits; // Low when both bits are set, about one cycle in four
    endtask

    task automatic clear_memory();
        for (logic [16:0] i = 17'h0; i < 17'h10000; i++)
            mem[i[15:0]] = 8'h00;
    endtask

    // One clock cycle of the memory model and the stimulus
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (write_pending) begin
            mem[pending_address] = pending_data;
            seen_writes.push_back({pending_address, pending_data});
        end
        test_reset = hold_reset;
        choose_rdy();
        @(negedge clk);
        write_pending   = !rw && rdy; // Write lands on the coming rising edge
        pending_address = address;
        pending_data    = data_out;
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic release_core();
        int waited;
        waited = 0;
        while (por_reset && waited < 50) begin
            next_cycle();
            waited++;
        end
        if (por_reset) begin
            $display("Power-on reset did not go low within 50 cycles");
            failure_count++;
            timed_out = 1'b1;
        end
        hold_reset = 1'b0;
    endtask

    task automatic wait_for_write(output logic [23:0] seen);
        int waited;
        waited = 0;
        seen   = 24'h0;
        while (seen_writes.size() == 0 && waited < 200) begin
            next_cycle();
            waited++;
        end
        if (seen_writes.size() == 0)
            timed_out = 1'b1;
        else
            seen = seen_writes.pop_front();
    endtask

    // Watch a short window for stray writes, then reset the core and wipe memory
    task automatic finish_test(input int test_number);
        logic [23:0] stray;
        repeat (8) next_cycle();
        while (seen_writes.size() != 0) begin
            stray = seen_writes.pop_front();
            failure_count++;
            $display("Test %0d wrote %h to %h, which was not expected", test_number,
                     stray[7:0], stray[23:8]);
        end
        hold_reset = 1'b1;
        repeat (10) next_cycle();
        clear_memory();
        seen_writes.delete();
    endtask

    initial begin
        int          fd;
        int          got;
        int          test_number;
        string       line;
        logic [7:0]  kind;
        logic [15:0] rec_address;
        logic [7:0]  rec_data;
        logic [23:0] seen;

        rdy             = 1'b1;
        test_reset      = 1'b1;
        hold_reset      = 1'b1;
        lfsr            = 8'd84;
        write_pending   = 1'b0;
        pending_address = 16'h0000;
        pending_data    = 8'h00;
        timed_out       = 1'b0;
        check_count     = 0;
        mismatch_count  = 0;
        failure_count   = 0;
        test_number     = 1;
        rec_address     = 16'h0000;
        rec_data        = 8'h00;
        clear_memory();

        fd = $fopen("test/cpu_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/cpu_tests.txt");
            failure_count++;
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            kind = (got > 0) ? line.getc(0) : 8'h00;
            if (kind == "P" || kind == "W") begin
                got = $sscanf(line.substr(2, line.len() - 1), "%h %h", rec_address, rec_data);
                if (got != 2) begin
                    failure_count++;
                    $display("Test %0d has a record without an address and a byte",
                             test_number);
                    kind = 8'h00;
                end
            end
            case (kind)
                "P": mem[rec_address] = rec_data;
                "W": begin
                    if (hold_reset)
                        release_core();
                    if (!timed_out) begin
                        wait_for_write(seen);
                        if (timed_out) begin
                            failure_count++;
                            $display("Test %0d: no write to %h arrived within 200 cycles",
                                     test_number, rec_address);
                        end else begin
                            check_value("address", seen[23:8], rec_address);
                            check_value("data_out", {8'h00, seen[7:0]}, {8'h00, rec_data});
                        end
                    end
                end
                "E": begin
                    finish_test(test_number);
                    test_number++;
                end
                default: ; // Comment or blank line
            endcase
        end
        if (fd != 0)
            $fclose(fd);

        $display("%0d checks, %0d mismatches, %0d other failures", check_count,
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0 && check_count > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/cpu_tests.txt
# Columns: record kind, address (hex), byte (hex)
# P preloads memory, W is the next expected write, E ends the test and resets the core
# LDA #$C5, ASL A, PHP, STA $80
P 0000 A9
P 0001 C5
P 0002 0A
P 0003 08
P 0004 85
P 0005 80
W 01FF A1
W 0080 8A
E
# LDA #$80, LSR $90, PHP
P 0000 A9
P 0001 80
P 0002 46
P 0003 90
P 0004 08
P 0090 81
W 0090 40
W 01FF 21
E
# LDX #$90, ASL $A0,X wraps to $30, PHP
P 0000 A2
P 0001 90
P 0002 16
P 0003 A0
P 0004 08
P 0030 41
P 00A0 77
W 0030 82
W 01FF A0
E
# ASL $1234, LSR $5678, PHP
P 0000 0E
P 0001 34
P 0002 12
P 0003 4E
P 0004 78
P 0005 56
P 0006 08
P 1234 3C
P 5678 F3
W 1234 78
W 5678 79
W 01FF 21
E
# LDA #$01, LSR A, PHP, NOP, PHP
P 0000 A9
P 0001 01
P 0002 4A
P 0003 08
P 0004 EA
P 0005 08
W 01FF 23
W 01FE 23
E
